/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

   localparam int WORD_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int OPCODE_W   = 6;
   localparam int FUNCT_W    = 6;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [WORD_W-1:0]     instr_t;
   typedef logic [OPCODE_W-1:0]   opcode_t;

   // primary opcodes
   localparam opcode_t OP_RTYPE = 6'b000000;
   localparam opcode_t OP_BEQ   = 6'b000100;
   localparam opcode_t OP_ADDI  = 6'b001000;
   localparam opcode_t OP_LW    = 6'b100011;
   localparam opcode_t OP_SW    = 6'b101011;

   // r-type funct field
   localparam logic [FUNCT_W-1:0] FUNCT_ADD = 6'b100000;
   localparam logic [FUNCT_W-1:0] FUNCT_SUB = 6'b100010;
   localparam logic [FUNCT_W-1:0] FUNCT_AND = 6'b100100;
   localparam logic [FUNCT_W-1:0] FUNCT_OR  = 6'b100101;
   localparam logic [FUNCT_W-1:0] FUNCT_SLT = 6'b101010;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

endpackage

`default_nettype wire

/* fetch/fetch_stage.sv */
`default_nettype none

module fetch_stage
   import mips_pkg::*;
   #(
   parameter int IMEM_DEPTH = 256
   )
   (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_step,
   input  logic                          i_imem_we,
   input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
   input  instr_t                        i_imem_data,
   input  logic                          i_stall,
   input  logic                          i_taken,
   input  word_t                         i_target,
   output word_t                         o_pc,
   output instr_t                        o_instr
   );

   localparam int IMEM_AW = $clog2(IMEM_DEPTH);

   instr_t               imem [IMEM_DEPTH];
   word_t                pc;
   word_t                pc_plus4;
   logic [IMEM_AW-1:0]   pc_idx;

   assign pc_plus4 = pc + 32'd4;
   assign pc_idx   = pc[IMEM_AW+1:2];

   // program load port, independent of step and reset
   always_ff @(posedge clk) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc      <= '0;
         o_pc    <= '0;
         o_instr <= '0;
      end else if (i_step) begin
         if (i_taken) begin
            // squash the slot in IF/ID
            pc      <= i_target;
            o_pc    <= '0;
            o_instr <= '0;
         end else if (!i_stall) begin
            pc      <= pc_plus4;
            o_pc    <= pc_plus4;
            o_instr <= imem[pc_idx];
         end
      end
   end

endmodule

`default_nettype wire

/* decode/register_file.sv */
`default_nettype none

module register_file
   import mips_pkg::*;
   (
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_step,
   input  logic      i_we,
   input  reg_addr_t i_waddr,
   input  word_t     i_wdata,
   input  reg_addr_t i_raddr_a,
   input  reg_addr_t i_raddr_b,
   output word_t     o_rdata_a,
   output word_t     o_rdata_b
   );

   word_t regs [1:31];
   logic  wr_en;

   assign wr_en = i_step && i_we && (i_waddr != '0);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // r0 reads zero, same-cycle write passes through
   assign o_rdata_a = (i_raddr_a == '0) ? '0 :
                      (wr_en && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
   assign o_rdata_b = (i_raddr_b == '0) ? '0 :
                      (wr_en && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`default_nettype none

module decode_stage
   import mips_pkg::*;
   (
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_step,
   input  word_t     i_pc,
   input  instr_t    i_instr,
   input  logic      i_taken,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_addr,
   input  word_t     i_wb_data,
   output logic      o_stall,
   output word_t     o_rs_val,
   output word_t     o_rt_val,
   output word_t     o_imm,
   output word_t     o_pc,
   output reg_addr_t o_rs,
   output reg_addr_t o_rt,
   output reg_addr_t o_dst,
   output alu_op_e   o_alu_op,
   output logic      o_alu_src,
   output logic      o_reg_write,
   output logic      o_mem_read,
   output logic      o_mem_write,
   output logic      o_mem_to_reg,
   output logic      o_branch
   );

   opcode_t    op;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   logic [5:0] funct;
   word_t      rs_val;
   word_t      rt_val;
   word_t      imm_ext;
   reg_addr_t  dst;
   alu_op_e    alu_op;
   logic       alu_src;
   logic       reg_write;
   logic       mem_read;
   logic       mem_write;
   logic       mem_to_reg;
   logic       branch;
   logic       uses_rt;
   logic       dec_valid;
   logic       bubble;

   assign op      = i_instr[31:26];
   assign rs      = i_instr[25:21];
   assign rt      = i_instr[20:16];
   assign rd      = i_instr[15:11];
   assign funct   = i_instr[5:0];
   assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};

   register_file register_file_i (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_step    (i_step),
      .i_we      (i_wb_we),
      .i_waddr   (i_wb_addr),
      .i_wdata   (i_wb_data),
      .i_raddr_a (rs),
      .i_raddr_b (rt),
      .o_rdata_a (rs_val),
      .o_rdata_b (rt_val)
   );

   always_comb begin
      alu_op     = ALU_ADD;
      alu_src    = 1'b0;
      reg_write  = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      branch     = 1'b0;
      uses_rt    = 1'b0;
      dec_valid  = 1'b1;
      dst        = rt;
      case (op)
         OP_RTYPE: begin
            dst       = rd;
            reg_write = 1'b1;
            uses_rt   = 1'b1;
            case (funct)
               FUNCT_ADD: alu_op = ALU_ADD;
               FUNCT_SUB: alu_op = ALU_SUB;
               FUNCT_AND: alu_op = ALU_AND;
               FUNCT_OR:  alu_op = ALU_OR;
               FUNCT_SLT: alu_op = ALU_SLT;
               default:   dec_valid = 1'b0;
            endcase
         end
         OP_ADDI: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         OP_LW: begin
            alu_src    = 1'b1;
            reg_write  = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
         end
         OP_SW: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
            uses_rt   = 1'b1;
         end
         OP_BEQ: begin
            alu_op  = ALU_SUB;
            branch  = 1'b1;
            uses_rt = 1'b1;
         end
         default: dec_valid = 1'b0;
      endcase
   end

   // load in ID/EX feeding this instruction
   assign o_stall = dec_valid && o_mem_read && (o_rt != '0) &&
                    ((o_rt == rs) || (uses_rt && (o_rt == rt)));

   assign bubble = i_taken || o_stall || !dec_valid;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_alu_op     <= ALU_ADD;
         o_alu_src    <= 1'b0;
         o_reg_write  <= 1'b0;
         o_mem_read   <= 1'b0;
         o_mem_write  <= 1'b0;
         o_mem_to_reg <= 1'b0;
         o_branch     <= 1'b0;
      end else if (i_step) begin
         o_alu_op     <= alu_op;
         o_alu_src    <= alu_src;
         o_reg_write  <= reg_write && !bubble;
         o_mem_read   <= mem_read && !bubble;
         o_mem_write  <= mem_write && !bubble;
         o_mem_to_reg <= mem_to_reg && !bubble;
         o_branch     <= branch && !bubble;
      end
   end

   always_ff @(posedge clk) begin
      if (i_step) begin
         o_rs_val <= rs_val;
         o_rt_val <= rt_val;
         o_imm    <= imm_ext;
         o_pc     <= i_pc;
         o_rs     <= rs;
         o_rt     <= rt;
         o_dst    <= dst;
      end
   end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`default_nettype none

module execute_stage
   import mips_pkg::*;
   (
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_step,
   input  word_t     i_rs_val,
   input  word_t     i_rt_val,
   input  word_t     i_imm,
   input  word_t     i_pc,
   input  reg_addr_t i_rs,
   input  reg_addr_t i_rt,
   input  reg_addr_t i_dst,
   input  alu_op_e   i_alu_op,
   input  logic      i_alu_src,
   input  logic      i_reg_write,
   input  logic      i_mem_read,
   input  logic      i_mem_write,
   input  logic      i_mem_to_reg,
   input  logic      i_branch,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_addr,
   input  word_t     i_wb_data,
   output logic      o_taken,
   output word_t     o_target,
   output word_t     o_alu_res,
   output word_t     o_store_data,
   output reg_addr_t o_dst,
   output logic      o_reg_write,
   output logic      o_mem_read,
   output logic      o_mem_write,
   output logic      o_mem_to_reg
   );

   word_t opnd_a;
   word_t opnd_b;
   word_t alu_b;
   word_t alu_res;
   word_t target;
   logic  equal;

   // EX/MEM has priority over the writeback bus
   assign opnd_a = (o_reg_write && o_dst != '0 && o_dst == i_rs) ? o_alu_res :
                   (i_wb_we && i_wb_addr == i_rs) ? i_wb_data : i_rs_val;
   assign opnd_b = (o_reg_write && o_dst != '0 && o_dst == i_rt) ? o_alu_res :
                   (i_wb_we && i_wb_addr == i_rt) ? i_wb_data : i_rt_val;

   assign alu_b = i_alu_src ? i_imm : opnd_b;

   always_comb begin
      case (i_alu_op)
         ALU_ADD: alu_res = opnd_a + alu_b;
         ALU_SUB: alu_res = opnd_a - alu_b;
         ALU_AND: alu_res = opnd_a & alu_b;
         ALU_OR:  alu_res = opnd_a | alu_b;
         ALU_SLT: alu_res = {31'b0, $signed(opnd_a) < $signed(alu_b)};
         default: alu_res = '0;
      endcase
   end

   assign equal  = (opnd_a == opnd_b);
   assign target = i_pc + {i_imm[29:0], 2'b00};

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_taken      <= 1'b0;
         o_reg_write  <= 1'b0;
         o_mem_read   <= 1'b0;
         o_mem_write  <= 1'b0;
         o_mem_to_reg <= 1'b0;
      end else if (i_step) begin
         // a taken branch kills the instruction behind it
         o_taken      <= !o_taken && i_branch && equal;
         o_reg_write  <= !o_taken && i_reg_write;
         o_mem_read   <= !o_taken && i_mem_read;
         o_mem_write  <= !o_taken && i_mem_write;
         o_mem_to_reg <= !o_taken && i_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (i_step) begin
         o_target     <= target;
         o_alu_res    <= alu_res;
         o_store_data <= opnd_b;
         o_dst        <= i_dst;
      end
   end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`default_nettype none

module memory_stage
   import mips_pkg::*;
   #(
   parameter int DMEM_DEPTH = 256
   )
   (
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_step,
   input  word_t     i_alu_res,
   input  word_t     i_store_data,
   input  reg_addr_t i_dst,
   input  logic      i_reg_write,
   input  logic      i_mem_read,
   input  logic      i_mem_write,
   input  logic      i_mem_to_reg,
   output logic      o_wb_we,
   output reg_addr_t o_wb_addr,
   output word_t     o_wb_data
   );

   localparam int DMEM_AW = $clog2(DMEM_DEPTH);

   word_t              dmem [DMEM_DEPTH];
   logic [DMEM_AW-1:0] dmem_idx;
   word_t              alu_res_q;
   word_t              load_q;
   logic               mem_to_reg_q;

   // word index from byte address
   assign dmem_idx = i_alu_res[DMEM_AW+1:2];

   always_ff @(posedge clk) begin
      if (i_step && i_mem_write) begin
         dmem[dmem_idx] <= i_store_data;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_wb_we      <= 1'b0;
         mem_to_reg_q <= 1'b0;
      end else if (i_step) begin
         o_wb_we      <= i_reg_write && (i_dst != '0);
         mem_to_reg_q <= i_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (i_step) begin
         o_wb_addr <= i_dst;
         alu_res_q <= i_alu_res;
         if (i_mem_read) begin
            load_q <= dmem[dmem_idx];
         end
      end
   end

   assign o_wb_data = mem_to_reg_q ? load_q : alu_res_q;

endmodule

`default_nettype wire

/* src/mips_core.sv */
`default_nettype none

module mips_core
   import mips_pkg::*;
   #(
   parameter int IMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
   )
   (
   input  logic                          clk,
   input  logic                          i_reset,
   input  logic                          i_step,
   input  logic                          i_imem_we,
   input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
   input  instr_t                        i_imem_data,
   output logic                          o_reg_write,
   output reg_addr_t                     o_reg_addr,
   output word_t                         o_result
   );

   // IF/ID
   word_t     if_pc;
   instr_t    if_instr;
   logic      id_stall;

   // ID/EX
   word_t     id_rs_val;
   word_t     id_rt_val;
   word_t     id_imm;
   word_t     id_pc;
   reg_addr_t id_rs;
   reg_addr_t id_rt;
   reg_addr_t id_dst;
   alu_op_e   id_alu_op;
   logic      id_alu_src;
   logic      id_reg_write;
   logic      id_mem_read;
   logic      id_mem_write;
   logic      id_mem_to_reg;
   logic      id_branch;

   // EX/MEM
   logic      ex_taken;
   word_t     ex_target;
   word_t     ex_alu_res;
   word_t     ex_store_data;
   reg_addr_t ex_dst;
   logic      ex_reg_write;
   logic      ex_mem_read;
   logic      ex_mem_write;
   logic      ex_mem_to_reg;

   // writeback bus
   logic      wb_we;
   reg_addr_t wb_addr;
   word_t     wb_data;

   fetch_stage #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) fetch_stage_i (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_step      (i_step),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .i_stall     (id_stall),
      .i_taken     (ex_taken),
      .i_target    (ex_target),
      .o_pc        (if_pc),
      .o_instr     (if_instr)
   );

   decode_stage decode_stage_i (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_step       (i_step),
      .i_pc         (if_pc),
      .i_instr      (if_instr),
      .i_taken      (ex_taken),
      .i_wb_we      (wb_we),
      .i_wb_addr    (wb_addr),
      .i_wb_data    (wb_data),
      .o_stall      (id_stall),
      .o_rs_val     (id_rs_val),
      .o_rt_val     (id_rt_val),
      .o_imm        (id_imm),
      .o_pc         (id_pc),
      .o_rs         (id_rs),
      .o_rt         (id_rt),
      .o_dst        (id_dst),
      .o_alu_op     (id_alu_op),
      .o_alu_src    (id_alu_src),
      .o_reg_write  (id_reg_write),
      .o_mem_read   (id_mem_read),
      .o_mem_write  (id_mem_write),
      .o_mem_to_reg (id_mem_to_reg),
      .o_branch     (id_branch)
   );

   execute_stage execute_stage_i (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_step       (i_step),
      .i_rs_val     (id_rs_val),
      .i_rt_val     (id_rt_val),
      .i_imm        (id_imm),
      .i_pc         (id_pc),
      .i_rs         (id_rs),
      .i_rt         (id_rt),
      .i_dst        (id_dst),
      .i_alu_op     (id_alu_op),
      .i_alu_src    (id_alu_src),
      .i_reg_write  (id_reg_write),
      .i_mem_read   (id_mem_read),
      .i_mem_write  (id_mem_write),
      .i_mem_to_reg (id_mem_to_reg),
      .i_branch     (id_branch),
      .i_wb_we      (wb_we),
      .i_wb_addr    (wb_addr),
      .i_wb_data    (wb_data),
      .o_taken      (ex_taken),
      .o_target     (ex_target),
      .o_alu_res    (ex_alu_res),
      .o_store_data (ex_store_data),
      .o_dst        (ex_dst),
      .o_reg_write  (ex_reg_write),
      .o_mem_read   (ex_mem_read),
      .o_mem_write  (ex_mem_write),
      .o_mem_to_reg (ex_mem_to_reg)
   );

   memory_stage #(
      .DMEM_DEPTH (DMEM_DEPTH)
   ) memory_stage_i (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_step       (i_step),
      .i_alu_res    (ex_alu_res),
      .i_store_data (ex_store_data),
      .i_dst        (ex_dst),
      .i_reg_write  (ex_reg_write),
      .i_mem_read   (ex_mem_read),
      .i_mem_write  (ex_mem_write),
      .i_mem_to_reg (ex_mem_to_reg),
      .o_wb_we      (wb_we),
      .o_wb_addr    (wb_addr),
      .o_wb_data    (wb_data)
   );

   assign o_reg_write = wb_we;
   assign o_reg_addr  = wb_addr;
   assign o_result    = wb_data;

endmodule

`default_nettype wire

/* tb/mips_asm.svh */
`ifndef MIPS_ASM_SVH
`define MIPS_ASM_SVH

// r-type layout is op, rs, rt, rd, shamt, funct
function automatic instr_t rtype_word(input logic [5:0] funct, input reg_addr_t rd,
                                      input reg_addr_t rs, input reg_addr_t rt);
   return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
endfunction

function automatic instr_t itype_word(input opcode_t op, input reg_addr_t rs,
                                      input reg_addr_t rt, input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic instr_t add_op(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
   return rtype_word(FUNCT_ADD, rd, rs, rt);
endfunction

function automatic instr_t sub_op(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
   return rtype_word(FUNCT_SUB, rd, rs, rt);
endfunction

function automatic instr_t and_op(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
   return rtype_word(FUNCT_AND, rd, rs, rt);
endfunction

function automatic instr_t or_op(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
   return rtype_word(FUNCT_OR, rd, rs, rt);
endfunction

function automatic instr_t slt_op(input reg_addr_t rd, input reg_addr_t rs, input reg_addr_t rt);
   return rtype_word(FUNCT_SLT, rd, rs, rt);
endfunction

function automatic instr_t addi_op(input reg_addr_t rt, input reg_addr_t rs, input logic [15:0] imm);
   return itype_word(OP_ADDI, rs, rt, imm);
endfunction

// offsets are in bytes for lw and sw, in words for beq
function automatic instr_t lw_op(input reg_addr_t rt, input reg_addr_t base, input logic [15:0] off);
   return itype_word(OP_LW, base, rt, off);
endfunction

function automatic instr_t sw_op(input reg_addr_t rt, input reg_addr_t base, input logic [15:0] off);
   return itype_word(OP_SW, base, rt, off);
endfunction

function automatic instr_t beq_op(input reg_addr_t rs, input reg_addr_t rt, input logic [15:0] off);
   return itype_word(OP_BEQ, rs, rt, off);
endfunction

`endif

/* tb/tb_mips_core.sv */
`default_nettype none

module tb_mips_core
   import mips_pkg::*;
   ;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int IMEM_DEPTH   = 256;
   localparam int IMEM_AW      = $clog2(IMEM_DEPTH);
   localparam int TIMEOUT      = 200;
   localparam int PAUSE_CYCLES = 20;

   logic               clk;
   logic               i_reset;
   logic               i_step;
   logic               i_imem_we;
   logic [IMEM_AW-1:0] i_imem_addr;
   instr_t             i_imem_data;
   logic               o_reg_write;
   reg_addr_t          o_reg_addr;
   word_t              o_result;

   instr_t    prog [$];
   reg_addr_t exp_addr [$];
   word_t     exp_data [$];
   word_t     rng_state;

   `include "mips_asm.svh"

   mips_core mips_core_i (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_step      (i_step),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .o_reg_write (o_reg_write),
      .o_reg_addr  (o_reg_addr),
      .o_result    (o_result)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic word_t xorshift32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic word_t sext16(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_reg_addr(input string name, input reg_addr_t actual,
                                 input reg_addr_t expected);
      if (actual !== expected) begin
         fail_now($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                            $time, name, actual, expected));
      end
   endtask

   task automatic check_word(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         fail_now($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                            $time, name, actual, expected));
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         fail_now($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                            $time, name, actual, expected));
      end
   endtask

   task automatic push_expected(input reg_addr_t addr, input word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // a write-back commits on the next edge only while i_step is high
   task automatic await_write_back();
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            fail_now("timed out waiting for the next register write-back");
         end
      end while (!(o_reg_write && i_step));
   endtask

   task automatic ensure_no_more_writes();
      repeat (TIMEOUT) begin
         @(negedge clk);
         if (o_reg_write && i_step) begin
            fail_now($sformatf("unexpected extra write-back to r%0d at %0t",
                               o_reg_addr, $time));
         end
      end
   endtask

   // outputs must freeze while the pipeline is held
   task automatic pause_step();
      logic      we_q;
      reg_addr_t addr_q;
      word_t     data_q;
      @(posedge clk);
      #2 i_step = 1'b0;
      @(negedge clk);
      we_q   = o_reg_write;
      addr_q = o_reg_addr;
      data_q = o_result;
      repeat (PAUSE_CYCLES - 1) begin
         @(negedge clk);
         check_flag("o_reg_write", o_reg_write, we_q);
         check_reg_addr("o_reg_addr", o_reg_addr, addr_q);
         check_word("o_result", o_result, data_q);
      end
      @(posedge clk);
      #2 i_step = 1'b1;
   endtask

   task automatic execute_program(input int pause_after);
      @(posedge clk);
      #2 i_step = 1'b0;
      for (int i = 0; i < IMEM_DEPTH; i++) begin
         i_imem_we   = 1'b1;
         i_imem_addr = IMEM_AW'(i);
         i_imem_data = (i < prog.size()) ? prog[i] : '0;
         @(posedge clk);
         #2;
      end
      i_imem_we = 1'b0;
      i_reset   = 1'b1;
      repeat (2) @(posedge clk);
      #2 i_reset = 1'b0;
      i_step = 1'b1;
      for (int i = 0; i < exp_addr.size(); i++) begin
         await_write_back();
         check_reg_addr("o_reg_addr", o_reg_addr, exp_addr[i]);
         check_word("o_result", o_result, exp_data[i]);
         if (i + 1 == pause_after) begin
            pause_step();
         end
      end
      ensure_no_more_writes();
      prog.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic alu_chain();
      logic [15:0] imm_a;
      logic [15:0] imm_b;
      word_t       r3;
      word_t       r4;
      word_t       r5;
      word_t       r6;
      imm_a = 16'(xorshift32() >> 16);
      imm_b = 16'(xorshift32() >> 16);
      $display("alu chain test");
      prog = '{addi_op(1, 0, imm_a), addi_op(2, 0, imm_b), add_op(3, 1, 2), sub_op(4, 3, 1),
               and_op(5, 4, 3), or_op(6, 5, 2), slt_op(7, 6, 4)};
      r3 = sext16(imm_a) + sext16(imm_b);
      r4 = r3 - sext16(imm_a);
      r5 = r4 & r3;
      r6 = r5 | sext16(imm_b);
      push_expected(1, sext16(imm_a));
      push_expected(2, sext16(imm_b));
      push_expected(3, r3);
      push_expected(4, r4);
      push_expected(5, r5);
      push_expected(6, r6);
      push_expected(7, ($signed(r6) < $signed(r4)) ? 32'd1 : 32'd0);
      execute_program(-1);
   endtask

   task automatic load_use();
      word_t x;
      word_t y;
      x = sext16(16'(xorshift32() >> 16));
      y = sext16(16'(xorshift32() >> 16));
      $display("load-use test");
      prog = '{addi_op(1, 0, x[15:0]), addi_op(2, 0, y[15:0]), sw_op(1, 0, 8), sw_op(2, 0, 12),
               lw_op(3, 0, 8), lw_op(4, 0, 12), add_op(5, 3, 4),
               lw_op(6, 0, 8), sub_op(7, 6, 4)};
      push_expected(1, x);
      push_expected(2, y);
      push_expected(3, x);
      push_expected(4, y);
      push_expected(5, x + y);
      push_expected(6, x);
      push_expected(7, x - y);
      execute_program(-1);
   endtask

   task automatic branch_skip();
      word_t v;
      v = sext16(16'(xorshift32() >> 16));
      $display("branch test");
      // taken beq at word 2 lands on word 6
      prog = '{addi_op(1, 0, v[15:0]), addi_op(2, 0, v[15:0]), beq_op(1, 2, 3),
               addi_op(3, 0, 1), addi_op(4, 0, 2), addi_op(5, 0, 3),
               addi_op(6, 0, 7), addi_op(7, 1, 1), beq_op(1, 7, 1),
               addi_op(8, 0, 11), addi_op(9, 0, 13)};
      push_expected(1, v);
      push_expected(2, v);
      push_expected(6, 32'd7);
      push_expected(7, v + 32'd1);
      push_expected(8, 32'd11);
      push_expected(9, 32'd13);
      execute_program(-1);
   endtask

   task automatic zero_register();
      word_t v;
      word_t w;
      v = sext16(16'(xorshift32() >> 16));
      w = sext16(16'(xorshift32() >> 16));
      $display("register zero test");
      prog = '{addi_op(1, 0, v[15:0]), addi_op(0, 0, w[15:0]), add_op(2, 0, 1), add_op(3, 1, 0)};
      push_expected(1, v);
      push_expected(2, v);
      push_expected(3, v);
      execute_program(-1);
   endtask

   task automatic step_hold();
      word_t a;
      word_t b;
      a = sext16(16'(xorshift32() >> 16));
      b = sext16(16'(xorshift32() >> 16));
      $display("step hold test");
      prog = '{addi_op(1, 0, a[15:0]), addi_op(2, 0, b[15:0]), add_op(3, 1, 2),
               sub_op(4, 1, 2), or_op(5, 3, 4)};
      push_expected(1, a);
      push_expected(2, b);
      push_expected(3, a + b);
      push_expected(4, a - b);
      push_expected(5, (a + b) | (a - b));
      execute_program(2);
   endtask

   initial begin
      rng_state   = 32'h4c88_9178;
      i_reset     = 1'b1;
      i_step      = 1'b0;
      i_imem_we   = 1'b0;
      i_imem_addr = '0;
      i_imem_data = '0;
      repeat (2) @(posedge clk);
      #2 i_reset = 1'b0;
      alu_chain();
      load_use();
      branch_skip();
      zero_register();
      step_hold();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tb
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
tb/tb_mips_core.sv
